// File: ppuPkg.sv
package ppuPkg;

   // CPU register addresses.
   localparam logic [15:0] AddrLcdc = 16'hFF40;
   localparam logic [15:0] AddrStat = 16'hFF41;
   localparam logic [15:0] AddrLy   = 16'hFF44;
   localparam logic [15:0] AddrLyc  = 16'hFF45;
   localparam logic [15:0] AddrBgp  = 16'hFF47;

   // CPU window onto video RAM.
   localparam logic [15:0] VramBase = 16'h8000;
   localparam logic [15:0] VramTop  = 16'h9FFF;

   // Dot and line timing.
   localparam logic [8:0] DotsPerLine   = 9'd456;
   localparam logic [8:0] LinesPerFrame = 9'd154;
   localparam logic [8:0] VisibleLines  = 9'd144;
   localparam logic [8:0] OamEnd        = 9'd80;
   localparam logic [8:0] DrawEnd       = 9'd252;

   localparam logic [7:0] LineWidth    = 8'd160;
   localparam logic [7:0] TilesPerLine = 8'd20;

   localparam int unsigned VramAddrBits = 13;
   localparam logic [7:0]  VramOffFill  = 8'hFF;
   localparam logic [4:0]  StatUnusedBits = 5'b11111;

   // Both tile maps live above offset 1800.
   localparam logic [1:0] MapPrefix = 2'b11;

   typedef enum logic [1:0] {
      HBlank  = 2'd0,
      VBlank  = 2'd1,
      OamScan = 2'd2,
      Drawing = 2'd3
   } ppuMode;

   // One VRAM offset, seen either as a map entry or as a tile row byte.
   typedef union packed {
      struct packed {
         logic [1:0] prefix;
         logic       mapSel;
         logic [4:0] row;
         logic [4:0] col;
      } map;
      struct packed {
         logic       block;
         logic [7:0] tileNum;
         logic [2:0] line;
         logic       plane;
      } tile;
   } ppuVramAddr;

endpackage

// File: ppuCpuPort.sv
`timescale 1ns/1ps

module ppuCpuPort (
   input  logic                             clock,
   input  logic                             reset,
   input  logic [15:0]                      cpuAddr,
   input  logic [7:0]                       cpuWriteData,
   input  logic                             cpuSelect,
   input  logic                             cpuWrite,
   input  logic                             cpuRead,
   output logic [7:0]                       cpuReadData,
   input  logic [7:0]                       ly,
   input  ppuPkg::ppuMode                   mode,
   input  logic                             drawing,
   input  ppuPkg::ppuVramAddr               fetchAddr,
   input  logic                             fetchRead,
   input  logic [7:0]                       vramReadData,
   output logic [ppuPkg::VramAddrBits-1:0]  vramAddr,
   output logic [7:0]                       vramWriteData,
   output logic                             vramWrite,
   output logic                             vramRead,
   output logic [7:0]                       lcdc,
   output logic [7:0]                       lyc,
   output logic [7:0]                       bgp
);

   logic       vramHit;
   logic       regWrite;
   logic       anyRead;
   logic [7:0] regData;
   logic [7:0] readData;
   logic       readFromVram;

   assign vramHit  = (cpuAddr >= ppuPkg::VramBase) && (cpuAddr <= ppuPkg::VramTop);
   assign regWrite = cpuSelect && cpuWrite;
   assign anyRead  = cpuSelect && cpuRead;

   always_ff @(posedge clock) begin
      if (reset) begin
         lcdc <= '0;
         lyc  <= '0;
         bgp  <= '0;
      end else if (regWrite) begin
         case (cpuAddr)
            ppuPkg::AddrLcdc: lcdc <= cpuWriteData;
            ppuPkg::AddrLyc:  lyc  <= cpuWriteData;
            ppuPkg::AddrBgp:  bgp  <= cpuWriteData;
            default: ;
         endcase
      end
   end

   // Unmapped registers and blocked video RAM reads return all ones.
   always_comb begin
      regData = ppuPkg::VramOffFill;
      case (cpuAddr)
         ppuPkg::AddrLcdc: regData = lcdc;
         ppuPkg::AddrStat: regData = {ppuPkg::StatUnusedBits, (ly == lyc), mode};
         ppuPkg::AddrLy:   regData = ly;
         ppuPkg::AddrLyc:  regData = lyc;
         ppuPkg::AddrBgp:  regData = bgp;
         default: ;
      endcase
   end

   // Remember where the pending read is answered from.
   always_ff @(posedge clock) begin
      if (reset) begin
         readFromVram <= 1'b0;
         readData     <= '0;
      end else if (anyRead) begin
         readFromVram <= vramHit && !drawing;
         readData     <= regData;
      end
   end

   assign cpuReadData = readFromVram ? vramReadData : readData;

   // The fetcher owns the memory for the whole drawing period.
   assign vramAddr      = drawing ? fetchAddr : cpuAddr[ppuPkg::VramAddrBits-1:0];
   assign vramWriteData = cpuWriteData;
   assign vramWrite     = !drawing && regWrite && vramHit;
   assign vramRead      = drawing ? fetchRead : (anyRead && vramHit);

endmodule

// File: ppuDotTimer.sv
`timescale 1ns/1ps

module ppuDotTimer (
   input  logic           clock,
   input  logic           reset,
   input  logic           lcdEnable,
   output ppuPkg::ppuMode mode,
   output logic [7:0]     ly,
   output logic           drawing,
   output logic           drawStart,
   output logic           vblankIrq
);

   logic [8:0] dot;
   logic       lineEnd;
   logic       frameEnd;
   logic       visible;

   assign lineEnd  = (dot == ppuPkg::DotsPerLine - 9'd1);
   assign frameEnd = ({1'b0, ly} == ppuPkg::LinesPerFrame - 9'd1);
   assign visible  = ({1'b0, ly} < ppuPkg::VisibleLines);

   // Counters hold at zero while the LCD is off.
   always_ff @(posedge clock) begin
      if (reset || !lcdEnable) begin
         dot <= '0;
         ly  <= '0;
      end else if (lineEnd) begin
         dot <= '0;
         ly  <= frameEnd ? 8'd0 : ly + 8'd1;
      end else begin
         dot <= dot + 9'd1;
      end
   end

   always_comb begin
      if (!visible) begin
         mode = ppuPkg::VBlank;
      end else if (dot < ppuPkg::OamEnd) begin
         mode = ppuPkg::OamScan;
      end else if (dot < ppuPkg::DrawEnd) begin
         mode = ppuPkg::Drawing;
      end else begin
         mode = ppuPkg::HBlank;
      end
   end

   assign drawing   = (mode == ppuPkg::Drawing);
   assign vblankIrq = (mode == ppuPkg::VBlank);

   // First dot of mode 3 on a visible line.
   assign drawStart = lcdEnable && visible && (dot == ppuPkg::OamEnd);

endmodule

// File: ppuBgFetcher.sv
`timescale 1ns/1ps

module ppuBgFetcher (
   input  logic                clock,
   input  logic                reset,
   input  logic                drawStart,
   input  logic [7:0]          ly,
   input  logic                mapSelect,
   input  logic                tileDataUnsigned,
   input  logic [7:0]          vramReadData,
   output ppuPkg::ppuVramAddr  fetchAddr,
   output logic                fetchRead,
   output logic [7:0]          pixelIndex,
   output logic [7:0][1:0]     pixelColor,
   output logic                pixelWrite,
   output logic                lineDone
);

   // Step 0 map read, 2 low plane read, 4 high plane read.
   // Odd steps are the wait cycles where the data comes back.
   logic               busy;
   logic [2:0]         step;
   logic [4:0]         col;
   logic [7:0]         tileNum;
   logic [7:0]         lowPlane;
   logic               lastCol;
   logic               lastTile;
   ppuPkg::ppuVramAddr mapAddr;
   ppuPkg::ppuVramAddr tileAddr;

   assign lastCol  = ({3'b000, col} == ppuPkg::TilesPerLine - 8'd1);
   assign lastTile = pixelWrite && lastCol;

   always_ff @(posedge clock) begin
      if (reset) begin
         busy     <= 1'b0;
         step     <= '0;
         col      <= '0;
         lineDone <= 1'b0;
      end else begin
         lineDone <= lastTile;
         if (drawStart) begin
            // The map read for column 0 is issued on this same cycle.
            busy <= 1'b1;
            step <= 3'd1;
            col  <= '0;
         end else if (busy) begin
            if (step == 3'd5) begin
               step <= '0;
               if (lastCol) begin
                  busy <= 1'b0;
                  col  <= '0;
               end else begin
                  col <= col + 5'd1;
               end
            end else begin
               step <= step + 3'd1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (busy && step == 3'd1) begin
         tileNum <= vramReadData;
      end
      if (busy && step == 3'd3) begin
         lowPlane <= vramReadData;
      end
   end

   always_comb begin
      mapAddr.map.prefix  = ppuPkg::MapPrefix;
      mapAddr.map.mapSel  = mapSelect;
      mapAddr.map.row     = ly[7:3];
      mapAddr.map.col     = col;
      // Signed numbering puts tiles 0 to 127 in the upper block.
      tileAddr.tile.block   = tileDataUnsigned ? 1'b0 : ~tileNum[7];
      tileAddr.tile.tileNum = tileNum;
      tileAddr.tile.line    = ly[2:0];
      tileAddr.tile.plane   = (step == 3'd4);
   end

   // Step is 0 while idle, so column 0 is already addressed at drawStart.
   assign fetchAddr = (step == 3'd0) ? mapAddr : tileAddr;
   assign fetchRead = drawStart || (busy && (step == 3'd0 || step == 3'd2 || step == 3'd4));

   assign pixelWrite = busy && (step == 3'd5);
   assign pixelIndex = {col, 3'b000};

   // Leftmost pixel comes from bit 7 of each plane.
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         pixelColor[i] = {vramReadData[7 - i], lowPlane[7 - i]};
      end
   end

endmodule

// File: ppuLineOut.sv
`timescale 1ns/1ps

module ppuLineOut (
   input  logic            clock,
   input  logic            reset,
   input  logic [7:0]      pixelIndex,
   input  logic [7:0][1:0] pixelColor,
   input  logic            pixelWrite,
   input  logic            lineDone,
   input  logic [7:0]      ly,
   input  logic [7:0]      bgp,
   input  logic            pixelReady,
   output logic            pixelValid,
   output logic [1:0]      pixelShade,
   output logic            pixelLast,
   output logic [7:0]      pixelLine
);

   logic [1:0] buildBuf [0:ppuPkg::LineWidth-1];
   logic [1:0] showBuf  [0:ppuPkg::LineWidth-1];
   logic [7:0] palette;
   logic [7:0] pixelCount;
   logic [1:0] color;
   logic       atEnd;

   // One tile of eight pixels per write.
   always_ff @(posedge clock) begin
      if (pixelWrite) begin
         for (int i = 0; i < 8; i++) begin
            buildBuf[pixelIndex + i] <= pixelColor[i];
         end
      end
   end

   // Swap in the finished line along with its palette and number.
   always_ff @(posedge clock) begin
      if (lineDone) begin
         showBuf   <= buildBuf;
         palette   <= bgp;
         pixelLine <= ly;
      end
   end

   assign atEnd = (pixelCount == ppuPkg::LineWidth - 8'd1);

   always_ff @(posedge clock) begin
      if (reset) begin
         pixelValid <= 1'b0;
         pixelCount <= '0;
      end else if (lineDone) begin
         // A new line drops whatever is left of the old one.
         pixelValid <= 1'b1;
         pixelCount <= '0;
      end else if (pixelValid && pixelReady) begin
         if (atEnd) begin
            pixelValid <= 1'b0;
            pixelCount <= '0;
         end else begin
            pixelCount <= pixelCount + 8'd1;
         end
      end
   end

   assign color      = showBuf[pixelCount];
   assign pixelShade = palette[{color, 1'b0} +: 2];
   assign pixelLast  = pixelValid && atEnd;

endmodule

// File: ppuTop.sv
`timescale 1ns/1ps

module ppuTop (
   input  logic                             clock,
   input  logic                             reset,
   input  logic [15:0]                      cpuAddr,
   input  logic [7:0]                       cpuWriteData,
   input  logic                             cpuSelect,
   input  logic                             cpuWrite,
   input  logic                             cpuRead,
   output logic [7:0]                       cpuReadData,
   output logic [ppuPkg::VramAddrBits-1:0]  vramAddr,
   output logic [7:0]                       vramWriteData,
   output logic                             vramWrite,
   output logic                             vramRead,
   input  logic [7:0]                       vramReadData,
   output logic                             vblankIrq,
   output logic                             pixelValid,
   output logic [1:0]                       pixelShade,
   output logic                             pixelLast,
   output logic [7:0]                       pixelLine,
   input  logic                             pixelReady
);

   logic [7:0]         lcdc;
   logic [7:0]         bgp;
   logic [7:0]         ly;
   ppuPkg::ppuMode     mode;
   logic               drawing;
   logic               drawStart;
   ppuPkg::ppuVramAddr fetchAddr;
   logic               fetchRead;
   logic [7:0]         pixelIndex;
   logic [7:0][1:0]    pixelColor;
   logic               pixelWrite;
   logic               lineDone;

   ppuCpuPort i_cpuPort (
      .clock(clock), .reset(reset),
      .cpuAddr(cpuAddr), .cpuWriteData(cpuWriteData), .cpuSelect(cpuSelect),
      .cpuWrite(cpuWrite), .cpuRead(cpuRead), .cpuReadData(cpuReadData),
      .ly(ly), .mode(mode), .drawing(drawing),
      .fetchAddr(fetchAddr), .fetchRead(fetchRead), .vramReadData(vramReadData),
      .vramAddr(vramAddr), .vramWriteData(vramWriteData),
      .vramWrite(vramWrite), .vramRead(vramRead),
      .lcdc(lcdc), .lyc(), .bgp(bgp)
   );

   ppuDotTimer i_dotTimer (
      .clock(clock), .reset(reset), .lcdEnable(lcdc[7]),
      .mode(mode), .ly(ly), .drawing(drawing),
      .drawStart(drawStart), .vblankIrq(vblankIrq)
   );

   ppuBgFetcher i_bgFetcher (
      .clock(clock), .reset(reset), .drawStart(drawStart), .ly(ly),
      .mapSelect(lcdc[3]), .tileDataUnsigned(lcdc[4]), .vramReadData(vramReadData),
      .fetchAddr(fetchAddr), .fetchRead(fetchRead),
      .pixelIndex(pixelIndex), .pixelColor(pixelColor),
      .pixelWrite(pixelWrite), .lineDone(lineDone)
   );

   ppuLineOut i_lineOut (
      .clock(clock), .reset(reset),
      .pixelIndex(pixelIndex), .pixelColor(pixelColor), .pixelWrite(pixelWrite),
      .lineDone(lineDone), .ly(ly), .bgp(bgp), .pixelReady(pixelReady),
      .pixelValid(pixelValid), .pixelShade(pixelShade),
      .pixelLast(pixelLast), .pixelLine(pixelLine)
   );

endmodule

// File: tbPpu_assert.sv
`timescale 1ns/1ps

module ppuChecks (
   input logic       clock,
   input logic       reset,
   input logic       pixelValid,
   input logic       pixelReady,
   input logic [1:0] pixelShade,
   input logic       pixelLast,
   input logic [7:0] pixelLine,
   input logic       vramWrite,
   input logic       drawing,
   input logic       fetchRead,
   input logic       vblankIrq
);

   int holdFails  = 0;
   int writeFails = 0;
   int irqFails   = 0;

   // Stream data is frozen while the sink stalls.
   stallHold: assert property (@(posedge clock) disable iff (reset)
      pixelValid && !pixelReady |=> pixelValid && $stable(pixelShade)
         && $stable(pixelLast) && $stable(pixelLine))
   else begin
      $error("Pixel stream changed while stalled");
      holdFails++;
   end

   // The fetcher owns video RAM during mode 3.
   noWriteWhileDrawing: assert property (@(posedge clock) disable iff (reset)
      fetchRead |-> drawing && !vramWrite)
   else begin
      $error("Fetcher used video RAM outside mode 3 or during a write");
      writeFails++;
   end

   noLineInVblank: assert property (@(posedge clock) disable iff (reset)
      $rose(pixelValid) |-> !vblankIrq)
   else begin
      $error("Line started streaming during vertical blank");
      irqFails++;
   end

endmodule

bind ppuTop ppuChecks i_checks (
   .clock(clock),
   .reset(reset),
   .pixelValid(pixelValid),
   .pixelReady(pixelReady),
   .pixelShade(pixelShade),
   .pixelLast(pixelLast),
   .pixelLine(pixelLine),
   .vramWrite(vramWrite),
   .drawing(drawing),
   .fetchRead(fetchRead),
   .vblankIrq(vblankIrq)
);

// File: tbPpu.sv
`timescale 1ns/1ps

module tbPpu;

   logic        clock = 1'b0;
   logic        reset;
   logic [15:0] cpuAddr;
   logic [7:0]  cpuWriteData;
   logic        cpuSelect;
   logic        cpuWrite;
   logic        cpuRead;
   logic [7:0]  cpuReadData;
   logic [12:0] vramAddr;
   logic [7:0]  vramWriteData;
   logic        vramWrite;
   logic        vramRead;
   logic [7:0]  vramReadData = 8'h00;
   logic        vblankIrq;
   logic        pixelValid;
   logic [1:0]  pixelShade;
   logic        pixelLast;
   logic [7:0]  pixelLine;
   logic        pixelReady = 1'b0;

   logic [7:0]  mem [0:8191];
   logic [31:0] randState = 32'd92598;
   logic        randomReady = 1'b0;
   int          errors = 0;
   int          streamErrors = 0;
   int          cycles = 0;
   int          lineCount = 0;
   int          pixCount = 0;
   int          nextLine = 0;
   int          cfgMap = 0;
   logic        cfgUnsigned = 1'b1;
   logic [7:0]  cfgBgp = 8'h00;
   logic [7:0]  cfgLyc = 8'h00;

   ppuTop i_dut (.*);

   always #10 clock = ~clock;

   function automatic logic [31:0] nextRand(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] fillByte(input int a);
      return 8'((a * 29) ^ (a >> 5) ^ (a >> 9));
   endfunction

   // Shade of pixel x on a line, worked out from map, tile rows and palette.
   function automatic logic [1:0] modelShade(input int line, input int x);
      int         mapOff;
      int         base;
      int         row;
      logic [7:0] tileNum;
      logic [7:0] lo;
      logic [7:0] hi;
      logic [1:0] c;
      mapOff  = 'h1800 + cfgMap * 'h400 + (line / 8) * 32 + x / 8;
      tileNum = mem[13'(mapOff)];
      base    = cfgUnsigned ? int'(tileNum) * 16 : 4096 + int'($signed(tileNum)) * 16;
      row     = base + (line % 8) * 2;
      lo      = mem[13'(row)];
      hi      = mem[13'(row + 1)];
      c       = {hi[7 - (x % 8)], lo[7 - (x % 8)]};
      return 2'(cfgBgp >> (2 * c));
   endfunction

   function automatic bit stepOk(input logic [7:0] a, input logic [7:0] b);
      return (b == a) || (b == ((a == 8'd153) ? 8'd0 : a + 8'd1));
   endfunction

   // Video RAM with one clock of read latency.
   always @(posedge clock) begin
      if (reset) begin
         for (int a = 0; a < 8192; a++) begin
            mem[a] <= fillByte(a);
         end
      end else begin
         if (vramWrite) begin
            mem[vramAddr] <= vramWriteData;
         end
         if (vramRead) begin
            vramReadData <= mem[vramAddr];
         end
      end
   end

   always @(posedge clock) begin
      randState  <= nextRand(randState);
      pixelReady <= randomReady ? (randState[17:16] != 2'b00) : 1'b1;
   end

   // Three frames of 70224 clocks plus setup fit well inside this.
   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles == 300000) begin
         $display("Timeout: the run did not finish within %0d cycles", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // Every transfer is checked against the model.
   always @(negedge clock) begin
      if (!reset && pixelValid && pixelReady) begin
         assert (pixelLine == 8'(nextLine)) else begin
            $display("ERROR at %0t: pixel line %0d, expected %0d", $time, pixelLine, nextLine);
            streamErrors++;
         end
         assert (pixelShade == modelShade(nextLine, pixCount)) else begin
            $display("ERROR at %0t: line %0d pixel %0d shade %0d, expected %0d", $time,
                     nextLine, pixCount, pixelShade, modelShade(nextLine, pixCount));
            streamErrors++;
         end
         assert (pixelLast == (pixCount == 159)) else begin
            $display("ERROR at %0t: pixelLast is %b at pixel %0d", $time, pixelLast, pixCount);
            streamErrors++;
         end
         if (pixCount == 159) begin
            pixCount = 0;
            lineCount++;
            nextLine = (nextLine == 143) ? 0 : nextLine + 1;
         end else begin
            pixCount++;
         end
      end
   end

   task automatic expectByte(input logic [7:0] got, input logic [7:0] exp, input string what);
      assert (got == exp) else begin
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic expectTrue(input logic ok, input string what);
      assert (ok) else begin
         $display("ERROR at %0t: %s is wrong", $time, what);
         errors++;
      end
   endtask

   task automatic writeReg(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clock);
      cpuAddr      <= addr;
      cpuWriteData <= data;
      cpuSelect    <= 1'b1;
      cpuWrite     <= 1'b1;
      @(posedge clock);
      cpuSelect <= 1'b0;
      cpuWrite  <= 1'b0;
   endtask

   // Irq is sampled in the cycle whose state the read data reflects.
   task automatic readReg(input logic [15:0] addr, output logic [7:0] data, output logic irq);
      @(posedge clock);
      cpuAddr   <= addr;
      cpuSelect <= 1'b1;
      cpuRead   <= 1'b1;
      @(negedge clock);
      irq = vblankIrq;
      @(posedge clock);
      cpuSelect <= 1'b0;
      cpuRead   <= 1'b0;
      @(negedge clock);
      data = cpuReadData;
   endtask

   task automatic checkRead(input logic [15:0] addr, input logic [7:0] exp, input string what);
      logic [7:0] data;
      logic       irq;
      readReg(addr, data, irq);
      expectByte(data, exp, what);
   endtask

   task automatic vramCheck(input logic [12:0] offset, input logic [7:0] data);
      writeReg(ppuPkg::VramBase + {3'b000, offset}, data);
      @(negedge clock);
      expectByte(mem[offset], data, "model memory after CPU write");
      checkRead(ppuPkg::VramBase + {3'b000, offset}, data, "CPU read of video RAM");
   endtask

   // Starts on line 0 in mode 2, so the first mode 3 seen is early in the window.
   task automatic lockoutCheck();
      logic [7:0] stat;
      logic [7:0] old;
      logic       irq;
      stat = 8'h00;
      while (stat[1:0] != 2'd3) begin
         readReg(ppuPkg::AddrStat, stat, irq);
      end
      checkRead(ppuPkg::VramBase + 16'h0200, 8'hFF, "video RAM read in mode 3");
      old = mem[13'h0200];
      writeReg(ppuPkg::VramBase + 16'h0200, ~old);
      while (stat[1:0] != 2'd0) begin
         readReg(ppuPkg::AddrStat, stat, irq);
      end
      expectByte(mem[13'h0200], old, "model memory after write in mode 3");
      checkRead(ppuPkg::VramBase + 16'h0200, old, "video RAM read after mode 3");
   endtask

   // Polls LY and STAT from line 0 until LY has wrapped after 153.
   task automatic runFrame();
      logic [7:0] ly1;
      logic [7:0] ly2;
      logic [7:0] stat;
      logic [7:0] prevLy;
      logic       irq;
      logic       unused;
      bit         sawTop;
      prevLy = 8'd0;
      sawTop = 1'b0;
      do begin
         readReg(ppuPkg::AddrLy, ly1, unused);
         readReg(ppuPkg::AddrStat, stat, irq);
         readReg(ppuPkg::AddrLy, ly2, unused);
         expectTrue(stepOk(prevLy, ly1) && stepOk(ly1, ly2), "LY sequence");
         expectTrue(irq == (stat[1:0] == 2'd1), "vblankIrq against STAT mode");
         if (ly1 == ly2) begin
            expectTrue((stat[1:0] == 2'd1) == (ly1 >= 8'd144), "STAT mode against LY");
            expectTrue(stat[2] == (ly1 == cfgLyc), "STAT coincidence bit");
         end
         if (ly2 == 8'd153) begin
            sawTop = 1'b1;
         end
         prevLy = ly2;
      end while (!(sawTop && ly2 == 8'd0));
   endtask

   initial begin
      logic [7:0] data;
      logic       irq;
      int         failures;
      reset        = 1'b1;
      cpuAddr      = 16'h0000;
      cpuWriteData = 8'h00;
      cpuSelect    = 1'b0;
      cpuWrite     = 1'b0;
      cpuRead      = 1'b0;
      repeat (3) @(posedge clock);
      reset <= 1'b0;

      writeReg(ppuPkg::AddrLyc, 8'h05);
      checkRead(ppuPkg::AddrLyc, 8'h05, "LYC");
      writeReg(ppuPkg::AddrBgp, 8'hE4);
      checkRead(ppuPkg::AddrBgp, 8'hE4, "BGP");
      writeReg(ppuPkg::AddrLcdc, 8'h18);
      checkRead(ppuPkg::AddrLcdc, 8'h18, "LCDC");
      checkRead(ppuPkg::AddrLy, 8'h00, "LY with LCD off");
      readReg(ppuPkg::AddrStat, data, irq);
      expectTrue(data[7:3] == 5'b11111 && !data[2], "STAT with LY unequal LYC");
      writeReg(ppuPkg::AddrLyc, 8'h00);
      readReg(ppuPkg::AddrStat, data, irq);
      expectTrue(data[2], "STAT with LY equal LYC");

      vramCheck(13'h0123, 8'h5A);
      vramCheck(13'h1821, 8'h3C);
      vramCheck(13'h1C42, 8'hC7);

      // Map 0 with unsigned tile numbers and a ready sink.
      cfgMap      = 0;
      cfgUnsigned = 1'b1;
      cfgBgp      = 8'hE4;
      cfgLyc      = 8'h40;
      writeReg(ppuPkg::AddrLyc, cfgLyc);
      writeReg(ppuPkg::AddrLcdc, 8'h90);
      lockoutCheck();
      runFrame();
      writeReg(ppuPkg::AddrLcdc, 8'h10);
      expectTrue(lineCount == 144, "line count for map 0");

      // Map 1 with signed tile numbers under back-pressure.
      cfgMap      = 1;
      cfgUnsigned = 1'b0;
      cfgBgp      = 8'h1B;
      cfgLyc      = 8'h8F;
      writeReg(ppuPkg::AddrBgp, cfgBgp);
      writeReg(ppuPkg::AddrLyc, cfgLyc);
      randomReady = 1'b1;
      writeReg(ppuPkg::AddrLcdc, 8'h88);
      runFrame();
      expectTrue(lineCount == 288, "line count for map 1");

      // Switch the LCD off during vertical blank.
      data = 8'h00;
      while (data < 8'd144) begin
         readReg(ppuPkg::AddrLy, data, irq);
      end
      writeReg(ppuPkg::AddrLcdc, 8'h08);

      checkRead(ppuPkg::AddrLy, 8'h00, "LY after LCD off");
      repeat (1000) begin
         @(negedge clock);
         expectTrue(!vblankIrq && !pixelValid, "outputs with LCD off");
      end

      failures = errors + streamErrors + i_dut.i_checks.holdFails
               + i_dut.i_checks.writeFails + i_dut.i_checks.irqFails;
      $display("%0d register errors, %0d stream errors, %0d assertion failures, %0d lines",
               errors, streamErrors, failures - errors - streamErrors, lineCount);
      if (failures == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
ppuPkg.sv
ppuCpuPort.sv
ppuDotTimer.sv
ppuBgFetcher.sv
ppuLineOut.sv
ppuTop.sv
tbPpu_assert.sv
tbPpu.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator and checks its output for the pass line.
cd "$(dirname "$0")" \
   && verilator --binary --assert -Wno-fatal --top-module tbPpu -f list.f -o tbPpu \
   && ./obj_dir/tbPpu +verilator+error+limit+1000 | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
   && echo "Simulation result: pass" \
   || { echo "Simulation result: fail"; exit 1; }
